/* tiled_ram.f */
rtl/ram_pkg.sv
rtl/valid_delay.sv
rtl/ram_addr_decoder_stage.sv
rtl/ram_addr_decoder.sv
rtl/ram_tile.sv
rtl/ram_read_mux.sv
rtl/tiled_ram.sv
sim/tiled_ram_asserts.sv
sim/tiled_ram_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the tiled_ram testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tiled_ram_tb -f tiled_ram.f -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/Vtiled_ram_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Testbench failed" sim.log; then
  echo "Simulation reported a failure, see sim.log"
  exit 1
fi

if ! grep -q "Testbench passed" sim.log; then
  echo "Simulation ended without a result, see sim.log"
  exit 1
fi

echo "Simulation passed"
exit 0

/* sim/tiled_ram_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module tiled_ram_tb;

  import ram_pkg::*;

  // --------------------
  // Constants and types
  // --------------------

  localparam int NUM_ROWS     = 28;
  localparam int NUM_RANDOM   = 200;
  localparam int DRAIN_CYCLES = READ_LATENCY + 2;
  // Request to tile strobe through the two decoder levels
  localparam int ROUTE_LATENCY = 2;
  // Reset, drains and the reset test add about 55 cycles on top
  localparam int TIMEOUT_CYCLES = NUM_ROWS + NUM_RANDOM + 100;

  // One table row whose exp only matters for reads
  typedef struct packed {
    logic [2:0]        test_id;
    logic              valid;
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] exp;
  } row_t;

  // Outstanding read and the cycle its answer is due
  typedef struct packed {
    int                due;
    logic [DATA_W-1:0] data;
  } pending_t;

  // Tile strobe expected for a request and the cycle it shows up
  typedef struct packed {
    int                    due;
    logic [TILE_COUNT-1:0] onehot;
  } route_t;

  logic              clk = 1'b0;
  logic              rst;
  logic              req_valid;
  ram_req_t          req;
  logic              rd_valid;
  logic [DATA_W-1:0] rd_data;

  row_t              table_rows [NUM_ROWS];
  // Reference memory model
  logic [DATA_W-1:0] ref_mem [1 << ADDR_W];
  logic              written [1 << ADDR_W];
  logic [ADDR_W-1:0] written_list [$];
  pending_t          exp_q [$];
  route_t            route_q [$];

  int          cycle = 0;
  int          errors = 0;
  int          checks = 0;
  int          test_errors_start = 0;
  logic [31:0] rand_state = 32'd53598;

  tiled_ram u_dut (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .req       (req),
    .rd_valid  (rd_valid),
    .rd_data   (rd_data)
  );

  always #10 clk = ~clk;

  // Cycle count and run limit
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Testbench failed");
      $finish;
    end
  end

  // --------------------
  // Helpers
  // --------------------

  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic row_t make_row(input logic [2:0] id, input logic valid, input logic we,
                                    input logic [ADDR_W-1:0] addr,
                                    input logic [DATA_W-1:0] wdata,
                                    input logic [DATA_W-1:0] exp);
    row_t r;
    r.test_id = id;
    r.valid   = valid;
    r.we      = we;
    r.addr    = addr;
    r.wdata   = wdata;
    r.exp     = exp;
    return r;
  endfunction

  function automatic string test_name(input int t);
    case (t)
      1: return "tile routing";
      2: return "pipelined reads";
      3: return "write then read";
      4: return "silent writes";
      5: return "random mix";
      default: return "reset mid-flight";
    endcase
  endfunction

  // Wait for the falling edge and check what the DUT shows in this cycle
  task automatic next_cycle();
    pending_t              pend;
    route_t                route;
    logic [TILE_COUNT-1:0] tile_exp;
    @(negedge clk);
    // Only the tile named by the top two address bits sees a request
    tile_exp = '0;
    if (route_q.size() != 0 && route_q[0].due == cycle) begin
      route    = route_q.pop_front();
      tile_exp = route.onehot;
      checks++;
    end
    if (u_dut.tile_valid !== tile_exp) begin
      $display("CHECK FAILED at %0t: tile_valid expected %b, got %b",
               $time, tile_exp, u_dut.tile_valid);
      errors++;
    end
    if (rd_valid) begin
      if (exp_q.size() == 0) begin
        $display("ERROR at %0t: rd_valid high with no read outstanding", $time);
        errors++;
      end else begin
        pend = exp_q.pop_front();
        checks++;
        if (pend.due != cycle) begin
          $display("ERROR at %0t: read answered in cycle %0d, due in cycle %0d",
                   $time, cycle, pend.due);
          errors++;
        end
        if (rd_data !== pend.data) begin
          $display("CHECK FAILED at %0t: rd_data expected %h, got %h",
                   $time, pend.data, rd_data);
          errors++;
        end
      end
    end
    // Reads past their due cycle never came back
    while (exp_q.size() != 0 && exp_q[0].due < cycle) begin
      pend = exp_q.pop_front();
      $display("ERROR at %0t: read due in cycle %0d got no response", $time, pend.due);
      errors++;
    end
  endtask

  // Drive one request and update the model
  task automatic issue(input row_t r);
    pending_t pend;
    route_t   route;
    next_cycle();
    req_valid = r.valid;
    req.we    = r.we;
    req.addr  = r.addr;
    req.wdata = r.wdata;
    if (r.valid && r.we) begin
      ref_mem[r.addr] = r.wdata;
      if (!written[r.addr]) begin
        written[r.addr] = 1'b1;
        written_list.push_back(r.addr);
      end
    end else if (r.valid) begin
      pend.due  = cycle + READ_LATENCY;
      pend.data = r.exp;
      exp_q.push_back(pend);
    end
    // Tile index is {addr[7], addr[6]}
    if (r.valid) begin
      route.due    = cycle + ROUTE_LATENCY;
      route.onehot = TILE_COUNT'(1) << {r.addr[7], r.addr[6]};
      route_q.push_back(route);
    end
  endtask

  // Idle long enough for every read in flight to answer
  task automatic drain();
    next_cycle();
    req_valid = 1'b0;
    repeat (DRAIN_CYCLES - 1) next_cycle();
  endtask

  task automatic report_test(input int t);
    $display("test %0d %s: %s, %0d errors", t, test_name(t),
             (errors == test_errors_start) ? "ok" : "mismatch", errors - test_errors_start);
  endtask

  task automatic load_table();
    logic [ADDR_W-1:0] edges [8];
    edges = '{8'h00, 8'h3F, 8'h40, 8'h7F, 8'h80, 8'hBF, 8'hC0, 8'hFF};
    // First and last word of each tile are written and read back
    for (int k = 0; k < 8; k++) begin
      table_rows[k]     = make_row(3'd1, 1'b1, 1'b1, edges[k], {8'hA0 + 8'(k), edges[k]}, 16'h0);
      table_rows[8 + k] = make_row(3'd1, 1'b1, 1'b0, edges[k], 16'h0, {8'hA0 + 8'(k), edges[k]});
    end
    // Back-to-back reads across all four tiles
    table_rows[16] = make_row(3'd2, 1'b1, 1'b0, 8'hFF, 16'h0, 16'hA7FF);
    table_rows[17] = make_row(3'd2, 1'b1, 1'b0, 8'h00, 16'h0, 16'hA000);
    table_rows[18] = make_row(3'd2, 1'b1, 1'b0, 8'hBF, 16'h0, 16'hA5BF);
    table_rows[19] = make_row(3'd2, 1'b1, 1'b0, 8'h40, 16'h0, 16'hA240);
    // Overwrite and read back on the very next cycle
    table_rows[20] = make_row(3'd3, 1'b1, 1'b1, 8'h80, 16'h5A5A, 16'h0);
    table_rows[21] = make_row(3'd3, 1'b1, 1'b0, 8'h80, 16'h0, 16'h5A5A);
    table_rows[22] = make_row(3'd3, 1'b1, 1'b1, 8'h3F, 16'h0F0F, 16'h0);
    table_rows[23] = make_row(3'd3, 1'b1, 1'b0, 8'h3F, 16'h0, 16'h0F0F);
    // Write burst that must stay silent
    table_rows[24] = make_row(3'd4, 1'b1, 1'b1, 8'h01, 16'h1111, 16'h0);
    table_rows[25] = make_row(3'd4, 1'b1, 1'b1, 8'h41, 16'h2222, 16'h0);
    table_rows[26] = make_row(3'd4, 1'b1, 1'b1, 8'h81, 16'h3333, 16'h0);
    table_rows[27] = make_row(3'd4, 1'b1, 1'b1, 8'hC1, 16'h4444, 16'h0);
  endtask

  // --------------------
  // Test sequence
  // --------------------

  initial begin
    int                idx;
    logic [ADDR_W-1:0] a;
    rst       = 1'b1;
    req_valid = 1'b0;
    req       = '0;
    foreach (written[i]) written[i] = 1'b0;
    load_table();
    repeat (3) next_cycle();
    rst = 1'b0;

    // Tests 1 to 4 from the table
    for (int t = 1; t <= 4; t++) begin
      test_errors_start = errors;
      for (int i = 0; i < NUM_ROWS; i++) begin
        if (int'(table_rows[i].test_id) == t) begin
          issue(table_rows[i]);
        end
      end
      drain();
      report_test(t);
    end

    // Random reads of written words and random writes
    test_errors_start = errors;
    for (int n = 0; n < NUM_RANDOM; n++) begin
      rand_state = next_random(rand_state);
      if (rand_state[0]) begin
        idx = int'(rand_state[15:8]) % written_list.size();
        a   = written_list[idx];
        issue(make_row(3'd5, 1'b1, 1'b0, a, 16'h0, ref_mem[a]));
      end else begin
        issue(make_row(3'd5, 1'b1, 1'b1, rand_state[15:8], rand_state[31:16], 16'h0));
      end
    end
    drain();
    report_test(5);

    // Reads in flight when reset hits are lost
    test_errors_start = errors;
    issue(make_row(3'd6, 1'b1, 1'b0, 8'h00, 16'h0, ref_mem[8'h00]));
    issue(make_row(3'd6, 1'b1, 1'b0, 8'h7F, 16'h0, ref_mem[8'h7F]));
    issue(make_row(3'd6, 1'b1, 1'b0, 8'hFF, 16'h0, ref_mem[8'hFF]));
    next_cycle();
    rst       = 1'b1;
    req_valid = 1'b0;
    exp_q.delete();
    route_q.delete();
    repeat (3) next_cycle();
    rst = 1'b0;
    // Any response now is a leftover
    repeat (DRAIN_CYCLES) next_cycle();
    // Memory keeps its contents through reset
    issue(make_row(3'd6, 1'b1, 1'b0, 8'h40, 16'h0, ref_mem[8'h40]));
    issue(make_row(3'd6, 1'b1, 1'b0, 8'hC0, 16'h0, ref_mem[8'hC0]));
    drain();
    report_test(6);

    $display("Summary: 6 tests, %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim/tiled_ram_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module tiled_ram_asserts (
  input wire logic                           clk,
  input wire logic                           rst,
  input wire logic                           req_valid,
  input wire ram_pkg::ram_req_t              req,
  input wire logic                           rd_valid,
  input wire logic [ram_pkg::TILE_COUNT-1:0] tile_valid
);

  import ram_pkg::*;

  // Reset seen at any of the last READ_LATENCY edges
  logic [READ_LATENCY-1:0] rst_hist;
  logic                    rd_req;
  logic                    path_clean;

  assign rd_req     = req_valid && !req.we;
  assign path_clean = (rst_hist == '0);

  always @(posedge clk) begin
    rst_hist <= {rst_hist[READ_LATENCY-2:0], rst};
  end

  // --------------------
  // Properties
  // --------------------

  // At most one tile addressed per cycle
  a_tile_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(tile_valid))
    else $error("tile_valid has more than one bit set: %b", tile_valid);

  // Every read answers after the full pipeline
  a_read_resp: assert property (@(posedge clk) disable iff (rst || !path_clean)
    $past(rd_req, READ_LATENCY) |-> rd_valid)
    else $error("read request got no rd_valid after %0d cycles", READ_LATENCY);

  // Writes and idle cycles give nothing
  a_no_extra_resp: assert property (@(posedge clk) disable iff (rst || !path_clean)
    !$past(rd_req, READ_LATENCY) |-> !rd_valid)
    else $error("rd_valid without a matching read request");

  // Reset clears the output valid
  a_reset_clear: assert property (@(posedge clk) $past(rst) |-> !rd_valid)
    else $error("rd_valid high in the cycle after reset");

endmodule

bind tiled_ram tiled_ram_asserts u_asserts (
  .clk        (clk),
  .rst        (rst),
  .req_valid  (req_valid),
  .req        (req),
  .rd_valid   (rd_valid),
  .tile_valid (tile_valid)
);

`default_nettype wire

/* rtl/tiled_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module tiled_ram (
  input  wire logic                       clk,
  input  wire logic                       rst,
  input  wire logic                       req_valid,
  input  wire ram_pkg::ram_req_t          req,
  output logic                            rd_valid,
  output logic      [ram_pkg::DATA_W-1:0] rd_data
);

  import ram_pkg::*;

  // Sideband split off the request
  ram_op_t req_op;

  // Decoder to tiles
  logic    [TILE_COUNT-1:0]                  tile_valid;
  logic    [TILE_COUNT-1:0][TILE_ADDR_W-1:0] tile_addr;
  ram_op_t [TILE_COUNT-1:0]                  tile_op;

  // Tiles to read mux
  logic [TILE_COUNT-1:0]             tile_rd_valid;
  logic [TILE_COUNT-1:0][DATA_W-1:0] tile_rd_data;

  assign req_op.we    = req.we;
  assign req_op.wdata = req.wdata;

  // Two cycles through the tree
  ram_addr_decoder u_decoder (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (req_valid),
    .in_addr    (req.addr),
    .in_op      (req_op),
    .tile_valid (tile_valid),
    .tile_addr  (tile_addr),
    .tile_op    (tile_op)
  );

  // Tile t holds addresses t*TILE_DEPTH up to (t+1)*TILE_DEPTH-1
  for (genvar t = 0; t < TILE_COUNT; t++) begin : gen_tile
    ram_tile u_tile (
      .clk      (clk),
      .rst      (rst),
      .valid    (tile_valid[t]),
      .addr     (tile_addr[t]),
      .op       (tile_op[t]),
      .rd_valid (tile_rd_valid[t]),
      .rd_data  (tile_rd_data[t])
    );
  end

  // Final register stage of the read path
  ram_read_mux u_read_mux (
    .clk           (clk),
    .rst           (rst),
    .tile_rd_valid (tile_rd_valid),
    .tile_rd_data  (tile_rd_data),
    .rd_valid      (rd_valid),
    .rd_data       (rd_data)
  );

endmodule

`default_nettype wire

/* rtl/ram_read_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module ram_read_mux (
  input  wire logic                                                clk,
  input  wire logic                                                rst,
  input  wire logic [ram_pkg::TILE_COUNT-1:0]                      tile_rd_valid,
  input  wire logic [ram_pkg::TILE_COUNT-1:0][ram_pkg::DATA_W-1:0] tile_rd_data,
  output logic                                                     rd_valid,
  output logic      [ram_pkg::DATA_W-1:0]                          rd_data
);

  import ram_pkg::*;

  logic              any_valid;
  logic [DATA_W-1:0] sel_data;

  // At most one tile answers per cycle
  assign any_valid = |tile_rd_valid;

  // AND-OR select, no priority needed for a one-hot valid
  always_comb begin
    sel_data = '0;
    for (int i = 0; i < TILE_COUNT; i++) begin
      sel_data = sel_data | ({DATA_W{tile_rd_valid[i]}} & tile_rd_data[i]);
    end
  end

  // Output valid register
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= any_valid;
    end
  end

  // Output data only loads on a response
  always_ff @(posedge clk) begin
    if (any_valid) begin
      rd_data <= sel_data;
    end
  end

endmodule

`default_nettype wire

/* rtl/ram_tile.sv */
`timescale 1ns/1ps
`default_nettype none

module ram_tile (
  input  wire logic                            clk,
  input  wire logic                            rst,
  input  wire logic                            valid,
  input  wire logic [ram_pkg::TILE_ADDR_W-1:0] addr,
  input  wire ram_pkg::ram_op_t                op,
  output logic                                 rd_valid,
  output logic      [ram_pkg::DATA_W-1:0]      rd_data
);

  import ram_pkg::*;

  // Storage, contents survive reset
  logic [DATA_W-1:0] mem [TILE_DEPTH];

  logic wr_en;
  logic rd_en;

  // Request type comes from the carried write enable
  assign wr_en = valid && op.we;
  assign rd_en = valid && !op.we;

  // --------------------
  // Write port
  // --------------------

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[addr] <= op.wdata;
    end
  end

  // --------------------
  // Read port
  // --------------------

  // One-cycle pulse per read
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_en;
    end
  end

  // Data holds between reads
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[addr];
    end
  end

endmodule

`default_nettype wire

/* rtl/ram_addr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module ram_addr_decoder (
  input  wire logic                                                      clk,
  input  wire logic                                                      rst,
  input  wire logic                                                      in_valid,
  input  wire logic [ram_pkg::ADDR_W-1:0]                                in_addr,
  input  wire ram_pkg::ram_op_t                                          in_op,
  output logic [ram_pkg::TILE_COUNT-1:0]                                 tile_valid,
  output logic [ram_pkg::TILE_COUNT-1:0][ram_pkg::TILE_ADDR_W-1:0]       tile_addr,
  output ram_pkg::ram_op_t [ram_pkg::TILE_COUNT-1:0]                     tile_op
);

  import ram_pkg::*;

  // Level 0 outputs, one per fork
  logic    [TREE_FORKS-1:0]                l0_valid;
  logic    [TREE_FORKS-1:0][L1_ADDR_W-1:0] l0_addr;
  ram_op_t [TREE_FORKS-1:0]                l0_op;

  // --------------------
  // Level 0
  // --------------------

  // addr[7] picks the upper or lower half of the tiles
  ram_addr_decoder_stage #(
    .payload_t        (ram_op_t),
    .IN_ADDR_W        (ADDR_W),
    .FORKS            (TREE_FORKS),
    .REGISTER_OUTPUTS (1'b1)
  ) u_stage_l0 (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_addr   (in_addr),
    .in_data   (in_op),
    .out_valid (l0_valid),
    .out_addr  (l0_addr),
    .out_data  (l0_op)
  );

  // --------------------
  // Level 1
  // --------------------

  // One stage per level-0 fork, selected by the next address bit
  // Tile index is {level-0 fork, level-1 fork}
  for (genvar i = 0; i < TREE_FORKS; i++) begin : gen_l1
    ram_addr_decoder_stage #(
      .payload_t        (ram_op_t),
      .IN_ADDR_W        (L1_ADDR_W),
      .FORKS            (TREE_FORKS),
      .REGISTER_OUTPUTS (1'b1)
    ) u_stage_l1 (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (l0_valid[i]),
      .in_addr   (l0_addr[i]),
      .in_data   (l0_op[i]),
      // Each stage fills a contiguous slice of the tile buses
      .out_valid (tile_valid[i*TREE_FORKS +: TREE_FORKS]),
      .out_addr  (tile_addr[i*TREE_FORKS +: TREE_FORKS]),
      .out_data  (tile_op[i*TREE_FORKS +: TREE_FORKS])
    );
  end

endmodule

`default_nettype wire

/* rtl/ram_addr_decoder_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module ram_addr_decoder_stage #(
  parameter type payload_t = logic,
  parameter int IN_ADDR_W = 2,
  // Number of output forks, power of 2
  parameter int FORKS = 2,
  // 1 gives one cycle of latency, 0 gives a combinational stage
  parameter bit REGISTER_OUTPUTS = 1'b1,
  localparam int OUT_ADDR_W = IN_ADDR_W - $clog2(FORKS)
) (
  input  wire logic                              clk,
  input  wire logic                              rst,
  input  wire logic                              in_valid,
  input  wire logic [IN_ADDR_W-1:0]              in_addr,
  input  wire payload_t                          in_data,
  output logic      [FORKS-1:0]                  out_valid,
  output logic      [FORKS-1:0][OUT_ADDR_W-1:0]  out_addr,
  output payload_t  [FORKS-1:0]                  out_data
);

  // Remaining address and payload travel together per fork
  typedef struct packed {
    logic [OUT_ADDR_W-1:0] addr;
    payload_t              data;
  } fork_t;

  logic [FORKS-1:0] fork_valid;

  // --------------------
  // Fork select
  // --------------------

  if (FORKS == 1) begin : gen_single_fork
    // Nothing to decode, the stage is only a delay
    assign fork_valid[0] = in_valid;
  end else begin : gen_multi_fork
    localparam int SEL_W = $clog2(FORKS);

    // Top address bits pick the fork
    for (genvar i = 0; i < FORKS; i++) begin : gen_sel
      assign fork_valid[i] = in_valid && (in_addr[IN_ADDR_W-1 -: SEL_W] == SEL_W'(i));
    end
  end

  // --------------------
  // Per-fork delay
  // --------------------

  // One register set per fork keeps fanout of each flop low
  for (genvar i = 0; i < FORKS; i++) begin : gen_fork
    fork_t fork_in;
    fork_t fork_out;

    // Lower address bits and payload are copied into every fork
    assign fork_in.addr = in_addr[OUT_ADDR_W-1:0];
    assign fork_in.data = in_data;

    valid_delay #(
      .payload_t  (fork_t),
      .NUM_STAGES (REGISTER_OUTPUTS ? 1 : 0)
    ) u_delay (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (fork_valid[i]),
      .in        (fork_in),
      .out_valid (out_valid[i]),
      .out       (fork_out)
    );

    assign out_addr[i] = fork_out.addr;
    assign out_data[i] = fork_out.data;
  end

endmodule

`default_nettype wire

/* rtl/valid_delay.sv */
`timescale 1ns/1ps
`default_nettype none

module valid_delay #(
  parameter type payload_t = logic,
  parameter int NUM_STAGES = 1
) (
  input  wire logic     clk,
  input  wire logic     rst,
  input  wire logic     in_valid,
  input  wire payload_t in,
  output logic          out_valid,
  output payload_t      out
);

  // Stage 0 is the input, stage NUM_STAGES is the output
  // With NUM_STAGES == 0 the chain collapses to a pass-through
  logic     stage_valid [NUM_STAGES+1];
  payload_t stage_data  [NUM_STAGES+1];

  assign stage_valid[0] = in_valid;
  assign stage_data[0]  = in;

  for (genvar s = 0; s < NUM_STAGES; s++) begin : gen_stage

    // Valid bits are control state and clear on reset
    always_ff @(posedge clk) begin
      if (rst) begin
        stage_valid[s+1] <= 1'b0;
      end else begin
        stage_valid[s+1] <= stage_valid[s];
      end
    end

    // Payload only moves with a valid
    // Idle cycles leave the register untouched
    always_ff @(posedge clk) begin
      if (stage_valid[s]) begin
        stage_data[s+1] <= stage_data[s];
      end
    end

  end

  // Last stage drives the outputs
  assign out_valid = stage_valid[NUM_STAGES];
  assign out       = stage_data[NUM_STAGES];

endmodule

`default_nettype wire

/* rtl/ram_pkg.sv */
`default_nettype none

package ram_pkg;

  // --------------------
  // Sizes
  // --------------------

  // Request address and data widths
  localparam int ADDR_W = 8;
  localparam int DATA_W = 16;

  // Decoder tree shape
  // Each stage strips log2(TREE_FORKS) bits off the top of the address
  localparam int TREE_FORKS = 2;
  localparam int TREE_LEVELS = 2;

  // Address width seen by the level-1 stages
  localparam int L1_ADDR_W = ADDR_W - $clog2(TREE_FORKS);

  // Tiles hang off the leaves of the tree
  localparam int TILE_COUNT = TREE_FORKS ** TREE_LEVELS;
  localparam int TILE_ADDR_W = L1_ADDR_W - $clog2(TREE_FORKS);
  localparam int TILE_DEPTH = 1 << TILE_ADDR_W;

  // Request to read response, 2 decoder + 1 tile + 1 mux
  localparam int READ_LATENCY = 4;

  // --------------------
  // Types
  // --------------------

  // Sideband carried next to the address through the tree
  typedef struct packed {
    logic              we;
    logic [DATA_W-1:0] wdata;
  } ram_op_t;

  // Top-level request
  typedef struct packed {
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } ram_req_t;

endpackage

`default_nettype wire
